/* Makefile */
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build output"

test:
	verilator --binary -j 0 -f sim.f --top-module tb_board
	@out="$$(./obj_dir/Vtb_board)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation completed successfully"

clean:
	rm -rf obj_dir

/* sim.f */
+incdir+source
source/board_pkg.sv
source/inmp441_mic_i2s_receiver.sv
source/level_meter.sv
source/seven_segment_scanner.sv
source/top.sv
source/board_specific_top.sv
tb/board_checker.sv
tb/tb_board.sv

/* source/board_macros.svh */
`ifndef BOARD_MACROS_SVH
`define BOARD_MACROS_SVH

// ********************
// board clock and widths.
// ********************

`define BOARD_CLK_MHZ   50

`define BOARD_W_KEY     2
`define BOARD_W_SW      10
`define BOARD_W_LED     10
`define BOARD_W_DIGIT   6
`define BOARD_W_GPIO    36

// ********************
// microphone and display timing.
// ********************

// clk cycles per half period of the i2s bit clock.
`define MIC_SCK_DIV     4

// clk cycles that each digit stays selected.
`define SCAN_CYCLES     16

`endif

/* source/board_pkg.sv */
`include "board_macros.svh"

package board_pkg;

    // ********************
    // microphone sample.
    // ********************

    // signed left-channel word, valid is a one-cycle strobe.
    typedef struct packed {
        logic signed [23:0] value;
        logic               valid;
    } mic_sample_t;

    // ********************
    // seven-segment stream.
    // ********************

    // active-high segments with the dot last, and a one-hot digit select.
    typedef struct packed {
        logic [7:0]                abcdefgh;
        logic [`BOARD_W_DIGIT-1:0] digit;
    } seg_frame_t;

    // ********************
    // i2s receive states.
    // ********************

    typedef enum logic [1:0] {
        IDLE_SLOT,
        SHIFT_BITS,
        DONE_WORD
    } i2s_state_t;

endpackage

/* source/board_specific_top.sv */
`timescale 1ns/1ps

`include "board_macros.svh"

module board_specific_top
(
    input  logic                     clk,
    input  logic [`BOARD_W_KEY-1:0]  key,
    input  logic [`BOARD_W_SW-1:0]   sw,
    output logic [`BOARD_W_LED-1:0]  ledr,
    output logic [7:0]               hex0,
    output logic [7:0]               hex1,
    output logic [7:0]               hex2,
    output logic [7:0]               hex3,
    output logic [7:0]               hex4,
    output logic [7:0]               hex5,
    input  logic [`BOARD_W_GPIO-1:0] gpio_in,
    output logic [`BOARD_W_GPIO-1:0] gpio_out
);

    logic                          rst;
    logic [`BOARD_W_KEY-1:0]       top_key;
    logic [`BOARD_W_SW-2:0]        top_sw;
    board_pkg::seg_frame_t         frame;
    board_pkg::mic_sample_t        mic;
    logic                          mic_sck;
    logic                          mic_ws;
    logic                          mic_lr;
    logic [7:0]                    hgfedcba;
    logic [7:0]                    hex_r [`BOARD_W_DIGIT];

    // ********************
    // reset and keys.
    // ********************

    // top switch is the reset, keys are active low on the board.
    assign rst     = sw[`BOARD_W_SW-1];
    assign top_sw  = sw[`BOARD_W_SW-2:0];
    assign top_key = ~key;

    top i_top
    (
        .clk   ( clk     ),
        .rst   ( rst     ),
        .key   ( top_key ),
        .sw    ( top_sw  ),
        .led   ( ledr    ),
        .frame ( frame   ),
        .mic   ( mic     )
    );

    // ********************
    // microphone pins.
    // ********************

    inmp441_mic_i2s_receiver i_microphone
    (
        .clk    ( clk        ),
        .rst    ( rst        ),
        .sd     ( gpio_in[0] ),
        .sck    ( mic_sck    ),
        .ws     ( mic_ws     ),
        .lr     ( mic_lr     ),
        .sample ( mic        )
    );

    // bit 2 powers the microphone, bit 4 is its ground.
    always_comb
    begin
        gpio_out    = '0;
        gpio_out[1] = mic_sck;
        gpio_out[2] = 1'b1;
        gpio_out[3] = mic_ws;
        gpio_out[4] = 1'b0;
        gpio_out[5] = mic_lr;
    end

    // ********************
    // segment latches.
    // ********************

    for (genvar i = 0; i < 8; i++)
    begin : g_rev
        assign hgfedcba[i] = frame.abcdefgh[7 - i];
    end

    // each digit keeps its pattern until it is scanned again.
    // board segments are active low, so reset leaves them dark.
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            for (int i = 0; i < `BOARD_W_DIGIT; i++)
                hex_r[i] <= '1;
        end
        else
        begin
            for (int i = 0; i < `BOARD_W_DIGIT; i++)
                if (frame.digit[i])
                    hex_r[i] <= ~hgfedcba;
        end
    end

    assign hex0 = hex_r[0];
    assign hex1 = hex_r[1];
    assign hex2 = hex_r[2];
    assign hex3 = hex_r[3];
    assign hex4 = hex_r[4];
    assign hex5 = hex_r[5];

endmodule

/* source/inmp441_mic_i2s_receiver.sv */
`timescale 1ns/1ps

`include "board_macros.svh"

module inmp441_mic_i2s_receiver
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   sd,
    output logic                   sck,
    output logic                   ws,
    output logic                   lr,
    output board_pkg::mic_sample_t sample
);

    localparam int div_w = $clog2(`MIC_SCK_DIV);

    logic [div_w-1:0]      div_cnt;
    logic                  sck_tick;
    logic                  sck_rise;
    logic                  sck_fall;
    logic [5:0]            bit_cnt;
    logic                  frame_seen;
    board_pkg::i2s_state_t state;
    logic [4:0]            shift_cnt;
    logic [23:0]           shift_reg;
    logic signed [23:0]    value_r;
    logic                  valid_r;

    // ********************
    // bit clock and word select.
    // ********************

    assign sck_tick = (div_cnt == div_w'(`MIC_SCK_DIV - 1));
    assign sck_rise = sck_tick & ~sck;
    assign sck_fall = sck_tick & sck;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            div_cnt <= '0;
            sck     <= 1'b0;
        end
        else if (sck_tick)
        begin
            div_cnt <= '0;
            sck     <= ~sck;
        end
        else
        begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    // 64 bit periods per frame, ws is high for the upper half.
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            bit_cnt    <= '0;
            frame_seen <= 1'b0;
        end
        else if (sck_fall)
        begin
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == 6'd63)
                frame_seen <= 1'b1;
        end
    end

    assign ws = bit_cnt[5];
    assign lr = 1'b0;

    // ********************
    // left-channel capture.
    // ********************

    // the first rising edge after ws falls is the delay slot.
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            state     <= board_pkg::IDLE_SLOT;
            shift_cnt <= '0;
            valid_r   <= 1'b0;
        end
        else
        begin
            valid_r <= 1'b0;
            case (state)
                board_pkg::IDLE_SLOT:
                begin
                    if (sck_rise && frame_seen && bit_cnt == 6'd0)
                    begin
                        shift_cnt <= '0;
                        state     <= board_pkg::SHIFT_BITS;
                    end
                end
                board_pkg::SHIFT_BITS:
                begin
                    if (sck_rise)
                    begin
                        shift_cnt <= shift_cnt + 1'b1;
                        if (shift_cnt == 5'd23)
                            state <= board_pkg::DONE_WORD;
                    end
                end
                board_pkg::DONE_WORD:
                begin
                    valid_r <= 1'b1;
                    state   <= board_pkg::IDLE_SLOT;
                end
                default:
                begin
                    state <= board_pkg::IDLE_SLOT;
                end
            endcase
        end
    end

    // msb first.
    always_ff @(posedge clk)
    begin
        if (state == board_pkg::SHIFT_BITS && sck_rise)
            shift_reg <= {shift_reg[22:0], sd};
        if (state == board_pkg::DONE_WORD)
            value_r <= shift_reg;
    end

    assign sample.value = value_r;
    assign sample.valid = valid_r;

endmodule

/* source/level_meter.sv */
`timescale 1ns/1ps

`include "board_macros.svh"

module level_meter
(
    input  logic                    clk,
    input  logic                    rst,
    input  logic [`BOARD_W_KEY-1:0] key,
    input  board_pkg::mic_sample_t  sample,
    output logic [23:0]             peak,
    output logic [`BOARD_W_LED-1:0] led
);

    logic [`BOARD_W_KEY-1:0] key_meta;
    logic [`BOARD_W_KEY-1:0] key_sync;
    logic [23:0]             neg_val;
    logic [23:0]             mag;
    logic                    hold;
    logic                    clear;

    // ********************
    // key synchronizers.
    // ********************

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            key_meta <= '0;
            key_sync <= '0;
        end
        else
        begin
            key_meta <= key;
            key_sync <= key_meta;
        end
    end

    assign hold  = key_sync[0];
    assign clear = key_sync[1];

    // ********************
    // magnitude and peak.
    // ********************

    // negative full scale has no positive twin, so it saturates.
    always_comb
    begin
        neg_val = -sample.value;
        if (!sample.value[23])
            mag = sample.value;
        else if (neg_val[23])
            mag = 24'h7f_ffff;
        else
            mag = neg_val;
    end

    // clear wins over hold.
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            peak <= '0;
        else if (clear)
            peak <= '0;
        else if (sample.valid && !hold && mag > peak)
            peak <= mag;
    end

    // ********************
    // led bar.
    // ********************

    // led i lights from 2^(13+i) upward.
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            led <= '0;
        end
        else
        begin
            for (int i = 0; i < `BOARD_W_LED; i++)
                led[i] <= (peak >= (24'd1 << (13 + i)));
        end
    end

endmodule

/* source/seven_segment_scanner.sv */
`timescale 1ns/1ps

`include "board_macros.svh"

module seven_segment_scanner
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic [23:0]           number,
    output board_pkg::seg_frame_t frame
);

    localparam int scan_w = $clog2(`SCAN_CYCLES);

    logic [scan_w-1:0] scan_cnt;
    logic [2:0]        digit_idx;
    logic [3:0]        nibble;
    logic [7:0]        seg;

    // ********************
    // digit scan.
    // ********************

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            scan_cnt  <= '0;
            digit_idx <= '0;
        end
        else if (scan_cnt == scan_w'(`SCAN_CYCLES - 1))
        begin
            scan_cnt <= '0;
            if (digit_idx == 3'(`BOARD_W_DIGIT - 1))
                digit_idx <= '0;
            else
                digit_idx <= digit_idx + 1'b1;
        end
        else
        begin
            scan_cnt <= scan_cnt + 1'b1;
        end
    end

    assign nibble = number[{digit_idx, 2'b00} +: 4];

    // ********************
    // hex to segments.
    // ********************

    // abcdefgh order with the dot always off.
    always_comb
    begin
        case (nibble)
            4'h0:    seg = 8'b1111_1100;
            4'h1:    seg = 8'b0110_0000;
            4'h2:    seg = 8'b1101_1010;
            4'h3:    seg = 8'b1111_0010;
            4'h4:    seg = 8'b0110_0110;
            4'h5:    seg = 8'b1011_0110;
            4'h6:    seg = 8'b1011_1110;
            4'h7:    seg = 8'b1110_0000;
            4'h8:    seg = 8'b1111_1110;
            4'h9:    seg = 8'b1111_0110;
            4'ha:    seg = 8'b1110_1110;
            4'hb:    seg = 8'b0011_1110;
            4'hc:    seg = 8'b1001_1100;
            4'hd:    seg = 8'b0111_1010;
            4'he:    seg = 8'b1001_1110;
            default: seg = 8'b1000_1110;
        endcase
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            frame.abcdefgh <= '0;
            frame.digit    <= '0;
        end
        else
        begin
            frame.abcdefgh <= seg;
            frame.digit    <= `BOARD_W_DIGIT'(1) << digit_idx;
        end
    end

endmodule

/* source/top.sv */
`timescale 1ns/1ps

`include "board_macros.svh"

module top
(
    input  logic                    clk,
    input  logic                    rst,
    input  logic [`BOARD_W_KEY-1:0] key,
    input  logic [`BOARD_W_SW-2:0]  sw,
    output logic [`BOARD_W_LED-1:0] led,
    output board_pkg::seg_frame_t   frame,
    input  board_pkg::mic_sample_t  mic
);

    logic [23:0] peak;

    // ********************
    // meter and display.
    // ********************

    level_meter i_level_meter
    (
        .clk    ( clk  ),
        .rst    ( rst  ),
        .key    ( key  ),
        .sample ( mic  ),
        .peak   ( peak ),
        .led    ( led  )
    );

    // the peak is shown as six hex digits.
    seven_segment_scanner i_scanner
    (
        .clk    ( clk   ),
        .rst    ( rst   ),
        .number ( peak  ),
        .frame  ( frame )
    );

endmodule

/* tb/board_checker.sv */
`timescale 1ns/1ps

`include "board_macros.svh"

module board_checker
(
    input  logic                     clk,
    input  logic [`BOARD_W_KEY-1:0]  key,
    input  logic [`BOARD_W_SW-1:0]   sw,
    input  logic [`BOARD_W_LED-1:0]  ledr,
    input  logic [7:0]               hex0,
    input  logic [7:0]               hex1,
    input  logic [7:0]               hex2,
    input  logic [7:0]               hex3,
    input  logic [7:0]               hex4,
    input  logic [7:0]               hex5,
    input  logic [`BOARD_W_GPIO-1:0] gpio_out,
    input  logic [23:0]              word,
    input  logic                     word_done,
    output logic                     busy,
    output int                       errors,
    output int                       checks
);

    logic [23:0] model_peak;
    logic [23:0] mag;
    int          led_wait;
    int          hex_wait;
    logic        in_reset;

    initial
    begin
        errors     = 0;
        checks     = 0;
        model_peak = '0;
        led_wait   = 0;
        hex_wait   = 0;
        in_reset   = 1'b0;
    end

    assign busy = (led_wait != 0) || (hex_wait != 0);

    // ********************
    // expected values.
    // ********************

    // segments a to g, then the dot.
    function automatic logic [7:0] segments_of(input logic [3:0] nibble);
        case (nibble)
            4'h0:    return 8'b1111_1100;
            4'h1:    return 8'b0110_0000;
            4'h2:    return 8'b1101_1010;
            4'h3:    return 8'b1111_0010;
            4'h4:    return 8'b0110_0110;
            4'h5:    return 8'b1011_0110;
            4'h6:    return 8'b1011_1110;
            4'h7:    return 8'b1110_0000;
            4'h8:    return 8'b1111_1110;
            4'h9:    return 8'b1111_0110;
            4'ha:    return 8'b1110_1110;
            4'hb:    return 8'b0011_1110;
            4'hc:    return 8'b1001_1100;
            4'hd:    return 8'b0111_1010;
            4'he:    return 8'b1001_1110;
            default: return 8'b1000_1110;
        endcase
    endfunction

    // board pins take the pattern reversed and active low.
    function automatic logic [7:0] expected_hex(input logic [3:0] nibble);
        logic [7:0] abc;
        logic [7:0] rev;
        abc = segments_of(nibble);
        for (int i = 0; i < 8; i++)
            rev[i] = abc[7 - i];
        return ~rev;
    endfunction

    function automatic logic [`BOARD_W_LED-1:0] expected_bar(input logic [23:0] peak);
        logic [`BOARD_W_LED-1:0] bar;
        for (int i = 0; i < `BOARD_W_LED; i++)
            bar[i] = (peak >> (13 + i)) != 0;
        return bar;
    endfunction

    function automatic logic [23:0] magnitude(input logic [23:0] value);
        if (value == 24'h80_0000)
            return 24'h7f_ffff;
        else if (value[23])
            return ~value + 24'd1;
        else
            return value;
    endfunction

    // ********************
    // comparisons.
    // ********************

    task automatic compare(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
        checks++;
        if (expected !== actual)
        begin
            errors++;
            $display("[FAIL] %s expected %0h actual %0h at %0t", name, expected, actual, $time);
        end
    endtask

    task automatic check_display(input logic [23:0] peak, input logic blank);
        logic [7:0] seen [`BOARD_W_DIGIT];
        seen[0] = hex0;
        seen[1] = hex1;
        seen[2] = hex2;
        seen[3] = hex3;
        seen[4] = hex4;
        seen[5] = hex5;
        for (int n = 0; n < `BOARD_W_DIGIT; n++)
        begin
            if (blank)
                compare($sformatf("hex%0d", n), 32'hff, 32'(seen[n]));
            else
                compare($sformatf("hex%0d", n), 32'(expected_hex(peak[4*n +: 4])),
                        32'(seen[n]));
        end
    endtask

    // power, ground, channel select and the unused pins never move.
    task automatic check_fixed_pins();
        compare("gpio_out[0]", 32'd0, 32'(gpio_out[0]));
        compare("gpio_out[2]", 32'd1, 32'(gpio_out[2]));
        compare("gpio_out[4]", 32'd0, 32'(gpio_out[4]));
        compare("gpio_out[5] lr", 32'd0, 32'(gpio_out[5]));
        compare("gpio_out[35:6]", 32'd0, 32'(gpio_out[`BOARD_W_GPIO-1:6]));
    endtask

    task automatic check_reset_values();
        check_display('0, 1'b1);
        compare("ledr", 32'd0, 32'(ledr));
        compare("gpio_out[1] sck", 32'd0, 32'(gpio_out[1]));
        compare("gpio_out[3] ws", 32'd0, 32'(gpio_out[3]));
        check_fixed_pins();
    endtask

    // ********************
    // reference model.
    // ********************

    // clear wins over hold, hold only blocks new samples.
    always @(negedge clk)
    begin
        if (sw[`BOARD_W_SW-1])
        begin
            model_peak = '0;
            led_wait   = 0;
            hex_wait   = 0;
            in_reset   = 1'b1;
            check_reset_values();
        end
        else
        begin
            if (in_reset)
            begin
                in_reset = 1'b0;
                check_display('0, 1'b1);
                compare("ledr", 32'd0, 32'(ledr));
            end
            mag = magnitude(word);
            if (!key[1])
                model_peak = '0;
            else if (word_done && key[0] && mag > model_peak)
                model_peak = mag;
            if (word_done)
            begin
                led_wait = 16;
                hex_wait = 130;
            end
            else
            begin
                if (led_wait > 0)
                begin
                    led_wait--;
                    if (led_wait == 0)
                        compare("ledr", 32'(expected_bar(model_peak)), 32'(ledr));
                end
                if (hex_wait > 0)
                begin
                    hex_wait--;
                    if (hex_wait == 0)
                    begin
                        check_display(model_peak, 1'b0);
                        check_fixed_pins();
                    end
                end
            end
        end
    end

endmodule

/* tb/tb_board.sv */
`timescale 1ns/1ps

`include "board_macros.svh"

module tb_board;

    localparam int wait_limit = 2000;

    logic                     clk;
    logic [`BOARD_W_KEY-1:0]  key;
    logic [`BOARD_W_SW-1:0]   sw;
    logic [`BOARD_W_LED-1:0]  ledr;
    logic [7:0]               hex0;
    logic [7:0]               hex1;
    logic [7:0]               hex2;
    logic [7:0]               hex3;
    logic [7:0]               hex4;
    logic [7:0]               hex5;
    logic [`BOARD_W_GPIO-1:0] gpio_in;
    logic [`BOARD_W_GPIO-1:0] gpio_out;
    logic [23:0]              word;
    logic                     word_done;
    logic                     busy;
    int                       errors;
    int                       checks;
    logic [31:0]              lfsr;
    logic                     stalled;

    always #50 clk = ~clk;

    board_specific_top DUT
    (
        .clk      ( clk      ),
        .key      ( key      ),
        .sw       ( sw       ),
        .ledr     ( ledr     ),
        .hex0     ( hex0     ),
        .hex1     ( hex1     ),
        .hex2     ( hex2     ),
        .hex3     ( hex3     ),
        .hex4     ( hex4     ),
        .hex5     ( hex5     ),
        .gpio_in  ( gpio_in  ),
        .gpio_out ( gpio_out )
    );

    board_checker i_board_checker
    (
        .clk       ( clk       ),
        .key       ( key       ),
        .sw        ( sw        ),
        .ledr      ( ledr      ),
        .hex0      ( hex0      ),
        .hex1      ( hex1      ),
        .hex2      ( hex2      ),
        .hex3      ( hex3      ),
        .hex4      ( hex4      ),
        .hex5      ( hex5      ),
        .gpio_out  ( gpio_out  ),
        .word      ( word      ),
        .word_done ( word_done ),
        .busy      ( busy      ),
        .errors    ( errors    ),
        .checks    ( checks    )
    );

    // ********************
    // random source.
    // ********************

    // taps 32, 22, 2 and 1.
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        logic fb;
        fb = state[31] ^ state[21] ^ state[1] ^ state[0];
        return {state[30:0], fb};
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr  = lfsr_next(lfsr);
            value = {value[30:0], lfsr[0]};
        end
    endtask

    // ********************
    // microphone model.
    // ********************

    // pins are looked at on the falling clk edge, where they are settled.
    task automatic wait_pin_fall(input int idx, input string what);
        logic prev;
        int   n;
        if (!stalled)
        begin
            @(negedge clk);
            prev = gpio_out[idx];
            n    = 0;
            @(negedge clk);
            while (!(prev && !gpio_out[idx]) && n < wait_limit)
            begin
                prev = gpio_out[idx];
                n++;
                @(negedge clk);
            end
            if (!(prev && !gpio_out[idx]))
            begin
                $display("timeout: %s did not fall within %0d clocks", what, wait_limit);
                stalled = 1'b1;
            end
        end
    endtask

    task automatic wait_checker_idle();
        int n;
        if (!stalled)
        begin
            n = 0;
            @(posedge clk);
            while (busy && n < wait_limit)
            begin
                n++;
                @(posedge clk);
            end
            if (busy)
            begin
                $display("timeout: checker still busy after %0d clocks", wait_limit);
                stalled = 1'b1;
            end
        end
    endtask

    // the msb goes out on the sck fall after the delay slot.
    task automatic send_frame(input logic [23:0] value, input logic hold, input logic clear);
        if (!stalled)
        begin
            @(posedge clk);
            key <= {~clear, ~hold};
            wait_pin_fall(3, "ws");
            for (int i = 23; i >= 0; i--)
            begin
                wait_pin_fall(1, "sck");
                @(posedge clk);
                gpio_in[0] <= value[i];
            end
            @(posedge clk);
            word      <= value;
            word_done <= 1'b1;
            @(posedge clk);
            word_done <= 1'b0;
            wait_checker_idle();
        end
    endtask

    // a random shift keeps small levels in the mix.
    task automatic random_frame(input logic with_keys);
        logic [31:0] raw;
        logic [31:0] shift;
        logic [31:0] pick;
        logic [23:0] value;
        draw_bits(24, raw);
        draw_bits(4, shift);
        draw_bits(3, pick);
        value = $signed(raw[23:0]) >>> shift[3:0];
        send_frame(value, with_keys && pick == 0, with_keys && pick == 1);
    endtask

    task automatic pulse_reset();
        @(posedge clk);
        sw[`BOARD_W_SW-1] <= 1'b1;
        repeat (5) @(posedge clk);
        sw[`BOARD_W_SW-1] <= 1'b0;
    endtask

    // ********************
    // test sequence.
    // ********************

    initial
    begin
        clk               = 1'b0;
        key               = '1;
        sw                = '0;
        sw[`BOARD_W_SW-1] = 1'b1;
        gpio_in           = '0;
        word              = '0;
        word_done         = 1'b0;
        lfsr              = 32'h5ba;
        stalled           = 1'b0;
        repeat (5) @(posedge clk);
        sw[`BOARD_W_SW-1] <= 1'b0;

        for (int f = 0; f < 10; f++)
            random_frame(1'b1);

        // clear, set a known level, then hold against louder input.
        send_frame(24'h00_1234, 1'b0, 1'b1);
        send_frame(24'h01_2345, 1'b0, 1'b0);
        send_frame(24'h80_0000, 1'b1, 1'b0);
        send_frame(24'h7f_ffff, 1'b1, 1'b0);
        send_frame(24'h81_2345, 1'b1, 1'b0);
        send_frame(24'hff_0000, 1'b0, 1'b0);
        random_frame(1'b0);
        send_frame(24'h45_6789, 1'b0, 1'b1);
        send_frame(24'h80_0000, 1'b0, 1'b0);

        pulse_reset();
        for (int f = 0; f < 4; f++)
            random_frame(1'b0);

        repeat (4) @(posedge clk);
        $display("checks: %0d, errors: %0d, timeouts: %0d", checks, errors, stalled);
        if (errors == 0 && !stalled)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule
